// ==== weight_rotator.f ====
+incdir+.
weight_rotator_pkg.sv
weight_bank_writer.sv
weight_bank_reader.sv
weight_bank_pair.sv
weight_rotator.sv
tb_clock_gen.sv
tb_weight_rotator.sv

// ==== Bender.yml ====
package:
  name: weight_rotator

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - weight_rotator_pkg.sv
      - weight_bank_writer.sv
      - weight_bank_reader.sv
      - weight_bank_pair.sv
      - weight_rotator.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_weight_rotator.sv

// ==== tb_weight_rotator.sv ====
/*
  Weight rotator testbench. Streams three headered weight sets with
  random gaps and checks the replayed output against a reference model
*/
`timescale 1ns/100ps

module tb_weight_rotator;
  import weight_rotator_pkg::*;

  typedef struct packed {
    beat_t data;
    logic  last;
  } in_beat_t;

  typedef struct packed {
    beat_t        data;
    logic         last;
    weight_user_t user;
  } out_beat_t;

  logic         aclk;
  logic         i_reset;
  logic         i_s_valid;
  logic         o_s_ready;
  beat_t        i_s_data;
  logic         i_s_last;
  logic         o_m_valid;
  logic         i_m_ready;
  beat_t        o_m_data;
  logic         o_m_last;
  weight_user_t o_m_user;

  logic [31:0]  lfsr_q = 32'h0c12_4406;
  in_beat_t     in_q[$];
  out_beat_t    exp_q[$];
  out_beat_t    exp_beat;  // Next beat the DUT should emit
  int           in_idx = 0;
  int           out_idx = 0;
  int           exp_total = 0;
  int           cycle_count = 0;
  int           cycle_limit = 100000;

  tb_clock_gen i_tb_clock_gen (
    .o_clk   (aclk),
    .o_reset (i_reset)
  );

  weight_rotator i_weight_rotator (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one shift per bit taken
  function automatic logic [63:0] lfsr_take(input int nbits);
    logic [63:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[62:0], fb};
    end
    return bits;
  endfunction

  function automatic header_t make_header(input int kw_1, input int kh_1, input int cin_1,
                                          input int cols_1, input int blocks_1);
    header_t hdr;
    hdr.kw_1     = kw_1;
    hdr.kh_1     = kh_1;
    hdr.cin_1    = cin_1;
    hdr.cols_1   = cols_1;
    hdr.blocks_1 = blocks_1;
    return hdr;
  endfunction

  // Queues the input beats of one transfer and the output beats it should produce
  task automatic add_transfer(input header_t hdr);
    beat_t     weights[$];
    in_beat_t  ib;
    out_beat_t ob;
    int        len;
    len     = (int'(hdr.kh_1) + 1) * (int'(hdr.cin_1) + 1);
    ib.data = beat_t'(lfsr_take($bits(beat_t)));
    ib.data[$bits(header_t)-1:0] = hdr;  // Bits above the header stay random
    ib.last = 1'b0;
    in_q.push_back(ib);
    for (int a = 0; a < len; a++) begin
      ib.data = beat_t'(lfsr_take($bits(beat_t)));
      ib.last = (a == len - 1);
      weights.push_back(ib.data);
      in_q.push_back(ib);
    end
    for (int b = int'(hdr.blocks_1); b >= 0; b--) begin
      for (int c = int'(hdr.cols_1); c >= 0; c--) begin
        for (int a = 0; a < len; a++) begin
          ob.data          = weights[a];
          ob.last          = (a == len - 1) && (c == 0) && (b == 0);
          ob.user.is_1x1   = (hdr.kw_1 == '0);
          ob.user.kw_1     = hdr.kw_1;
          ob.user.acc_last = (a == len - 1);
          ob.user.top      = (b == int'(hdr.blocks_1));
          ob.user.bottom   = (b == 0);
          exp_q.push_back(ob);
        end
      end
    end
  endtask

  task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    stop_with_failure();
  endtask

  task automatic report_failure(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    stop_with_failure();
  endtask

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b0;
    add_transfer(make_header(2, 2, 3, 2, 2));  // 3x3 kernel, 3 columns, 3 blocks
    add_transfer(make_header(0, 0, 5, 1, 1));  // 1x1 kernel
    add_transfer(make_header(1, 1, 2, 0, 0));  // One column, one block, back in bank 0
    exp_total   = exp_q.size();
    exp_beat    = exp_q[0];
    cycle_limit = 4 * (in_q.size() + exp_total) + 200;
    wait (out_idx == exp_total);
    repeat (10) @(posedge aclk);  // Leaves room for a stray extra beat
    if (in_idx == in_q.size() && out_idx == exp_total) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("** Error at %0t ns: %0d of %0d input beats and %0d of %0d output beats moved",
               $time, in_idx, in_q.size(), out_idx, exp_total);
      stop_with_failure();
    end
  end

  // Random valid gaps on the input and random ready on the output
  always @(posedge aclk) begin
    if (i_reset) begin
      i_s_valid <= 1'b0;
      i_m_ready <= 1'b0;
    end else begin
      if (i_s_valid && o_s_ready) begin
        in_idx = in_idx + 1;
      end
      if (!i_s_valid || o_s_ready) begin
        if (in_idx < in_q.size() && lfsr_take(2) != 0) begin
          i_s_valid <= 1'b1;
          i_s_data  <= in_q[in_idx].data;
          i_s_last  <= in_q[in_idx].last;
        end else begin
          i_s_valid <= 1'b0;
        end
      end
      i_m_ready <= (lfsr_take(2) != 0);  // Ready about three cycles in four
    end
  end

  // Reference model steps on every output handshake
  always @(posedge aclk) begin
    if (!i_reset && o_m_valid && i_m_ready) begin
      out_idx <= out_idx + 1;
      if (out_idx + 1 < exp_total) begin
        exp_beat <= exp_q[out_idx + 1];
      end
    end
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_failure("run did not finish within the cycle limit");
    end
  end

  // ========================================
  // Checks
  // ========================================
  a_reset_quiet: assert property (@(posedge aclk) i_reset |=> !o_s_ready && !o_m_valid)
    else report_failure("ready or valid high during reset or on the cycle after it");

  a_no_extra: assert property (@(posedge aclk) disable iff (i_reset)
    o_m_valid && i_m_ready |-> out_idx < exp_total)
    else report_failure("output beat beyond the end of the expected stream");

  a_data: assert property (@(posedge aclk) disable iff (i_reset)
    o_m_valid && i_m_ready |-> o_m_data == exp_beat.data)
    else report_mismatch("o_m_data", $sampled(o_m_data), $sampled(exp_beat.data));

  a_last: assert property (@(posedge aclk) disable iff (i_reset)
    o_m_valid && i_m_ready |-> o_m_last == exp_beat.last)
    else report_mismatch("o_m_last", $sampled(o_m_last), $sampled(exp_beat.last));

  a_user: assert property (@(posedge aclk) disable iff (i_reset)
    o_m_valid && i_m_ready |-> o_m_user == exp_beat.user)
    else report_mismatch("o_m_user", $sampled(o_m_user), $sampled(exp_beat.user));

  a_hold: assert property (@(posedge aclk) disable iff (i_reset)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) && $stable(o_m_last)
                                && $stable(o_m_user))
    else report_failure("output changed or valid dropped while i_m_ready was low");

endmodule

// ==== tb_clock_gen.sv ====
/*
  Testbench clock and reset. 8 ns clock, reset held high for the
  first five rising edges
*/
`timescale 1ns/100ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;  // 8 ns period
  end

  initial begin
    o_reset = 1'b1;
    repeat (5) @(posedge o_clk);
    o_reset <= 1'b0;  // Released on a rising edge like any other input
  end

endmodule

// ==== weight_rotator.sv ====
/*
  Weight rotator top. A writer fills one bank from the input stream
  while a reader replays the other bank on the output stream
*/
`timescale 1ns/100ps

module weight_rotator (
  input  logic                             aclk,
  input  logic                             i_reset,
  input  logic                             i_s_valid,
  output logic                             o_s_ready,
  input  weight_rotator_pkg::beat_t        i_s_data,
  input  logic                             i_s_last,
  output logic                             o_m_valid,
  input  logic                             i_m_ready,
  output weight_rotator_pkg::beat_t        o_m_data,
  output logic                             o_m_last,
  output weight_rotator_pkg::weight_user_t o_m_user
);
  import weight_rotator_pkg::*;

  // Writer side
  logic        w_bank;
  bank_write_t wr;
  logic        hdr_load;
  header_t     hdr;
  logic        w_done;
  logic        w_free;

  // Reader side
  logic        r_bank;
  addr_t       r_addr;
  logic        r_release;
  logic        r_full;
  header_t     r_hdr;
  beat_t       r_data;

  weight_bank_writer i_weight_bank_writer (
    .aclk       (aclk),
    .i_reset    (i_reset),
    .i_s_valid  (i_s_valid),
    .o_s_ready  (o_s_ready),
    .i_s_data   (i_s_data),
    .i_s_last   (i_s_last),
    .i_w_free   (w_free),
    .o_w_bank   (w_bank),
    .o_wr       (wr),
    .o_hdr_load (hdr_load),
    .o_hdr      (hdr),
    .o_w_done   (w_done)
  );

  weight_bank_reader i_weight_bank_reader (
    .aclk        (aclk),
    .i_reset     (i_reset),
    .i_r_full    (r_full),
    .i_r_hdr     (r_hdr),
    .i_r_data    (r_data),
    .i_m_ready   (i_m_ready),
    .o_r_bank    (r_bank),
    .o_r_addr    (r_addr),
    .o_r_release (r_release),
    .o_m_valid   (o_m_valid),
    .o_m_data    (o_m_data),
    .o_m_last    (o_m_last),
    .o_m_user    (o_m_user)
  );

  weight_bank_pair i_weight_bank_pair (
    .aclk        (aclk),
    .i_reset     (i_reset),
    .i_w_bank    (w_bank),
    .i_wr        (wr),
    .i_hdr_load  (hdr_load),
    .i_hdr       (hdr),
    .i_w_done    (w_done),
    .o_w_free    (w_free),
    .i_r_bank    (r_bank),
    .i_r_addr    (r_addr),
    .i_r_release (r_release),
    .o_r_full    (r_full),
    .o_r_hdr     (r_hdr),
    .o_r_data    (r_data)
  );

endmodule

// ==== weight_bank_pair.sv ====
/*
  Weight bank pair. Two weight memories with their headers and the
  full flags that pass each bank from the writer to the reader
*/
`timescale 1ns/100ps
`include "weight_rotator_defines.svh"

module weight_bank_pair (
  input  logic                            aclk,
  input  logic                            i_reset,
  input  logic                            i_w_bank,
  input  weight_rotator_pkg::bank_write_t i_wr,
  input  logic                            i_hdr_load,
  input  weight_rotator_pkg::header_t     i_hdr,
  input  logic                            i_w_done,
  output logic                            o_w_free,
  input  logic                            i_r_bank,
  input  weight_rotator_pkg::addr_t       i_r_addr,
  input  logic                            i_r_release,
  output logic                            o_r_full,
  output weight_rotator_pkg::header_t     o_r_hdr,
  output weight_rotator_pkg::beat_t       o_r_data
);
  import weight_rotator_pkg::*;

  beat_t   mem [2][`WR_BANK_DEPTH];
  header_t hdr_q [2];
  logic    full_q [2];

  // ========================================
  // Storage
  // ========================================
  always_ff @(posedge aclk) begin
    if (i_wr.wen) begin
      mem[i_w_bank][i_wr.addr] <= i_wr.data;
    end
    if (i_hdr_load) begin
      hdr_q[i_w_bank] <= i_hdr;  // Header travels with its bank
    end
  end

  // ========================================
  // Full flags
  // ========================================
  // Set by the writer when a bank is complete, cleared by the reader when
  // it has replayed that bank for every column and block.
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      full_q[0] <= 1'b0;
      full_q[1] <= 1'b0;
    end else begin
      if (i_w_done) begin
        full_q[i_w_bank] <= 1'b1;
      end
      if (i_r_release) begin
        full_q[i_r_bank] <= 1'b0;
      end
    end
  end

  assign o_w_free = !full_q[i_w_bank];
  assign o_r_full = full_q[i_r_bank];
  assign o_r_hdr  = hdr_q[i_r_bank];
  assign o_r_data = mem[i_r_bank][i_r_addr];  // Asynchronous read

endmodule

// ==== weight_bank_reader.sv ====
/*
  Weight bank reader. Sweeps a full bank once per column per block,
  drives the output stream and hands the bank back when finished
*/
`timescale 1ns/100ps
`include "weight_rotator_defines.svh"

module weight_bank_reader (
  input  logic                             aclk,
  input  logic                             i_reset,
  input  logic                             i_r_full,
  input  weight_rotator_pkg::header_t      i_r_hdr,
  input  weight_rotator_pkg::beat_t        i_r_data,
  input  logic                             i_m_ready,
  output logic                             o_r_bank,
  output weight_rotator_pkg::addr_t        o_r_addr,
  output logic                             o_r_release,
  output logic                             o_m_valid,
  output weight_rotator_pkg::beat_t        o_m_data,
  output logic                             o_m_last,
  output weight_rotator_pkg::weight_user_t o_m_user
);
  import weight_rotator_pkg::*;

  r_state_t                   state_q;
  r_state_t                   state_d;
  addr_t                      addr_q;
  addr_t                      len_1;
  addr_t                      kh_ext;
  addr_t                      cin_ext;
  logic [`WR_COLS_BITS-1:0]   cols_q;
  logic [`WR_BLOCKS_BITS-1:0] blocks_q;
  logic                       m_handshake;
  logic                       acc_last;

  // Sweep length minus one, (kh_1+1)*(cin_1+1)-1 expanded
  assign kh_ext  = addr_t'(i_r_hdr.kh_1);
  assign cin_ext = addr_t'(i_r_hdr.cin_1);
  assign len_1   = kh_ext * cin_ext + kh_ext + cin_ext;

  assign m_handshake = o_m_valid && i_m_ready;
  assign acc_last    = (addr_q == len_1);

  // ========================================
  // Next state
  // ========================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      R_IDLE:   if (i_r_full) state_d = R_READ;
      R_READ:   if (m_handshake && o_m_last) state_d = R_SWITCH;
      R_SWITCH: state_d = R_IDLE;
      default:  state_d = R_IDLE;
    endcase
  end

  // ========================================
  // Sweep, column and block counters
  // ========================================
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state_q  <= R_IDLE;
      o_r_bank <= 1'b0;
      addr_q   <= '0;
      cols_q   <= '0;
      blocks_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == R_IDLE && i_r_full) begin
        addr_q   <= '0;
        cols_q   <= i_r_hdr.cols_1;
        blocks_q <= i_r_hdr.blocks_1;
      end else if (m_handshake) begin
        if (acc_last) begin
          addr_q <= '0;  // Replay the bank from the top
          if (cols_q == '0) begin
            cols_q   <= i_r_hdr.cols_1;
            blocks_q <= blocks_q - 1'b1;
          end else begin
            cols_q <= cols_q - 1'b1;
          end
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
      if (o_r_release) begin
        o_r_bank <= ~o_r_bank;
      end
    end
  end

  // ========================================
  // Stream outputs
  // ========================================
  assign o_r_addr    = addr_q;
  assign o_r_release = (state_q == R_SWITCH);
  assign o_m_valid   = (state_q == R_READ);
  assign o_m_data    = i_r_data;  // Bank is read combinationally, so data holds with the address
  assign o_m_last    = acc_last && (cols_q == '0) && (blocks_q == '0);

  always_comb begin
    o_m_user.is_1x1   = (i_r_hdr.kw_1 == '0);
    o_m_user.kw_1     = i_r_hdr.kw_1;
    o_m_user.acc_last = acc_last;
    o_m_user.top      = (blocks_q == i_r_hdr.blocks_1);
    o_m_user.bottom   = (blocks_q == '0);
  end

endmodule

// ==== weight_bank_writer.sv ====
/*
  Weight bank writer. Waits for a free bank, takes the header beat,
  then writes the weight beats in order and marks the bank full
*/
`timescale 1ns/100ps

module weight_bank_writer (
  input  logic                            aclk,
  input  logic                            i_reset,
  input  logic                            i_s_valid,
  output logic                            o_s_ready,
  input  weight_rotator_pkg::beat_t       i_s_data,
  input  logic                            i_s_last,
  input  logic                            i_w_free,
  output logic                            o_w_bank,
  output weight_rotator_pkg::bank_write_t o_wr,
  output logic                            o_hdr_load,
  output weight_rotator_pkg::header_t     o_hdr,
  output logic                            o_w_done
);
  import weight_rotator_pkg::*;

  w_state_t state_q;
  w_state_t state_d;
  addr_t    waddr_q;
  logic     s_handshake;

  assign s_handshake = i_s_valid && o_s_ready;

  // ========================================
  // Next state
  // ========================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      W_IDLE:   if (i_w_free) state_d = W_HEADER;
      W_HEADER: if (s_handshake) state_d = W_WRITE;
      W_WRITE:  if (s_handshake && i_s_last) state_d = W_DONE;
      W_DONE:   state_d = W_IDLE;
      default:  state_d = W_IDLE;
    endcase
  end

  // ========================================
  // Outputs
  // ========================================
  assign o_s_ready  = (state_q == W_HEADER) || (state_q == W_WRITE);
  assign o_hdr_load = s_handshake && (state_q == W_HEADER);
  assign o_hdr      = header_t'(i_s_data[$bits(header_t)-1:0]);  // Header sits in the low bits
  assign o_w_done   = (state_q == W_DONE);

  always_comb begin
    o_wr.wen  = s_handshake && (state_q == W_WRITE);
    o_wr.addr = waddr_q;
    o_wr.data = i_s_data;
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state_q  <= W_IDLE;
      waddr_q  <= '0;
      o_w_bank <= 1'b0;
    end else begin
      state_q <= state_d;
      if (o_hdr_load) begin
        waddr_q <= '0;  // Each bank fills from address 0
      end else if (o_wr.wen) begin
        waddr_q <= waddr_q + 1'b1;
      end
      if (o_w_done) begin
        o_w_bank <= ~o_w_bank;  // Move on to the other bank
      end
    end
  end

endmodule

// ==== weight_rotator_pkg.sv ====
/*
  Weight rotator types. Beat, address, header, output user field,
  bank write bundle and the FSM state encodings
*/
`include "weight_rotator_defines.svh"

package weight_rotator_pkg;

  typedef logic [`WR_BEAT_WIDTH-1:0] beat_t;
  typedef logic [`WR_ADDR_BITS-1:0]  addr_t;

  // Lives in the low bits of the first beat, blocks_1 on top
  typedef struct packed {
    logic [`WR_BLOCKS_BITS-1:0] blocks_1;
    logic [`WR_COLS_BITS-1:0]   cols_1;
    logic [`WR_CIN_BITS-1:0]    cin_1;
    logic [`WR_KH_BITS-1:0]     kh_1;
    logic [`WR_KW_BITS-1:0]     kw_1;
  } header_t;

  typedef struct packed {
    logic                   is_1x1;
    logic [`WR_KW_BITS-1:0] kw_1;
    logic                   acc_last;  // Last beat of a sweep
    logic                   top;       // First block
    logic                   bottom;    // Last block
  } weight_user_t;

  typedef struct packed {
    logic  wen;
    addr_t addr;
    beat_t data;
  } bank_write_t;

  // ========================================
  // FSM states
  // ========================================
  typedef enum logic [1:0] {W_IDLE, W_HEADER, W_WRITE, W_DONE} w_state_t;
  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} r_state_t;

endpackage

// ==== weight_rotator_defines.svh ====
/*
  Weight rotator sizing. Word and core widths, kernel, channel,
  column and block maxima, and the widths derived from them
*/
`ifndef WEIGHT_ROTATOR_DEFINES_SVH
`define WEIGHT_ROTATOR_DEFINES_SVH

// ========================================
// Base sizes
// ========================================
`define WR_WORD_WIDTH    8
`define WR_CORES         2
`define WR_KERNEL_W_MAX  3
`define WR_KERNEL_H_MAX  3
`define WR_CIN_MAX       64
`define WR_COLS_MAX      16
`define WR_BLOCKS_MAX    8

// ========================================
// Derived sizes
// ========================================
`define WR_BEAT_WIDTH    (`WR_WORD_WIDTH * `WR_CORES * `WR_KERNEL_W_MAX)
`define WR_BANK_DEPTH    (`WR_KERNEL_H_MAX * `WR_CIN_MAX)
`define WR_ADDR_BITS     $clog2(`WR_BANK_DEPTH)

// Header field widths, each holding a count minus one
`define WR_KW_BITS       $clog2(`WR_KERNEL_W_MAX)
`define WR_KH_BITS       $clog2(`WR_KERNEL_H_MAX)
`define WR_CIN_BITS      $clog2(`WR_CIN_MAX)
`define WR_COLS_BITS     $clog2(`WR_COLS_MAX)
`define WR_BLOCKS_BITS   $clog2(`WR_BLOCKS_MAX)

`endif
